//--- zports_pkg.sv
// zports package: port numbers, xt register indices, reset values and bus types
`default_nettype none

package zports_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] port_addr_t;
  typedef logic [7:0]  page_t;
  typedef logic [31:0] xt_pages_t;   // page 3 in the top byte

  localparam int KEYS_W      = 5;
  localparam int KJOY_W      = 5;
  localparam int DRIVE_W     = 2;
  localparam int CACHECONF_W = 4;

  // low address byte of the internal ports
  localparam byte_t PORT_FE     = 8'hFE;
  localparam byte_t PORT_FD     = 8'hFD;   // 7FFD paging
  localparam byte_t PORT_XT     = 8'hAF;
  localparam byte_t PORT_VGCOM  = 8'h1F;
  localparam byte_t PORT_VGTRK  = 8'h3F;
  localparam byte_t PORT_VGSEC  = 8'h5F;
  localparam byte_t PORT_VGDAT  = 8'h7F;
  localparam byte_t PORT_VGSYS  = 8'hFF;
  localparam byte_t PORT_KJOY   = 8'h1F;   // shared with VGCOM, vg_open decides
  localparam byte_t PORT_KMOUSE = 8'hDF;
  localparam byte_t PORT_SDCFG  = 8'h77;
  localparam byte_t PORT_SDDAT  = 8'h57;

  // nnAF register index, high address byte
  localparam byte_t XT_VCONF     = 8'h00;
  localparam byte_t XT_VPAGE     = 8'h01;
  localparam byte_t XT_TSCONF    = 8'h06;
  localparam byte_t XT_PALSEL    = 8'h07;
  localparam byte_t XT_BORDER    = 8'h0F;
  localparam byte_t XT_RAMPAGE   = 8'h10;  // 10..13
  localparam byte_t XT_SYSCONF   = 8'h20;
  localparam byte_t XT_MEMCONF   = 8'h21;
  localparam byte_t XT_HSINT     = 8'h22;
  localparam byte_t XT_FDDVIRT   = 8'h29;
  localparam byte_t XT_INTMASK   = 8'h2A;
  localparam byte_t XT_CACHECONF = 8'h2B;
  localparam byte_t XT_XSTAT     = 8'h00;  // read side only

  localparam byte_t     MEMCONF_RST = 8'h04;  // no rom map
  localparam byte_t     INTMASK_RST = 8'h01;  // frame int only
  localparam xt_pages_t RAMPAGE_RST = {8'h00, 8'h02, 8'h05, 8'h00};

  typedef struct packed {
    port_addr_t addr;
    byte_t      din;
    logic       iord;
    logic       iowr;
    logic       iord_s;
    logic       iowr_s;
    logic       opfetch;
    logic       dos;
    logic       vdos;
  } zbus_t;

  typedef struct packed {
    logic fe;
    logic xt;
    logic fd;
    logic vg;
    logic vgsys;
    logic kjoy;
    logic kmouse;
    logic sdcfg;
    logic sddat;
  } port_hit_t;

  typedef struct packed {
    logic vconf;
    logic vpage;
    logic border;
    logic tsconf;
    logic palsel;
    logic hint_beg;
  } video_wr_t;

endpackage

`default_nettype wire

//--- port_decode.sv
// port decoder: hit flags for the internal ports and bus direction control
`timescale 1ns/100ps
`default_nettype none

module port_decode (
  input  var zports_pkg::zbus_t     bus,
  input  var logic                  vg_open,
  output var zports_pkg::port_hit_t hits,
  output var logic                  sd_allow,
  output var logic                  porthit,
  output var logic                  external_port,
  output var logic                  dataout
);

  import zports_pkg::*;

  byte_t loa;
  logic  vg_port;

  assign loa = bus.addr[7:0];

  assign vg_port = (loa == PORT_VGCOM) || (loa == PORT_VGTRK) ||
                   (loa == PORT_VGSEC) || (loa == PORT_VGDAT);

  // z-controller is reachable outside dos or from virtual dos
  assign sd_allow = !bus.dos || bus.vdos;

  always_comb
  begin
    hits        = '0;
    hits.fe     = (loa == PORT_FE);
    hits.xt     = (loa == PORT_XT);
    hits.fd     = (loa == PORT_FD) && !bus.addr[15];  // 7FFD only
    hits.vg     = vg_port && vg_open;
    hits.vgsys  = (loa == PORT_VGSYS) && vg_open;
    hits.kjoy   = (loa == PORT_KJOY) && !bus.dos && !vg_open;
    hits.kmouse = (loa == PORT_KMOUSE);
    hits.sdcfg  = (loa == PORT_SDCFG) && sd_allow;
    hits.sddat  = (loa == PORT_SDDAT) && sd_allow;
  end

  assign porthit = |hits;

  // wd1793 data comes from outside the block
  assign external_port = hits.vg;

  assign dataout = porthit && bus.iord && !external_port;

endmodule

`default_nettype wire

//--- xt_regs.sv
// extended config registers at nnAF, 7FFD paging with locks, video write strobes
`timescale 1ns/100ps
`default_nettype none

module xt_regs (
  input  var logic                                clk,
  input  var logic                                rst,
  input  var zports_pkg::zbus_t                   bus,
  input  var zports_pkg::port_hit_t               hits,
  output var zports_pkg::byte_t                   fddvirt,
  output var zports_pkg::byte_t                   sysconf,
  output var zports_pkg::byte_t                   memconf,
  output var zports_pkg::byte_t                   intmask,
  output var logic [zports_pkg::CACHECONF_W-1:0]  cacheconf,
  output var logic                                pwr_up,
  output var zports_pkg::xt_pages_t               pages,
  output var zports_pkg::xt_pages_t               xt_page,
  output var zports_pkg::video_wr_t               video_wr
);

  import zports_pkg::*;

  byte_t     hoa;
  byte_t     din;
  logic      xt_wr;
  logic      p7ffd_wr;
  logic      lock48;
  logic      m1_lock128;
  logic      lock128;
  logic      lock128_3;
  page_t [3:0] rampage;

  assign hoa = bus.addr[15:8];
  assign din = bus.din;

  assign xt_wr    = hits.xt && bus.iowr_s;
  assign p7ffd_wr = hits.fd && bus.iowr_s && !lock48;

  assign pages   = rampage;
  assign xt_page = rampage;

  // video strobes, same cycle as the write
  always_comb
  begin
    video_wr          = '0;
    video_wr.vconf    = xt_wr && (hoa == XT_VCONF);
    video_wr.vpage    = xt_wr && (hoa == XT_VPAGE);
    video_wr.border   = xt_wr && (hoa == XT_BORDER);
    video_wr.tsconf   = xt_wr && (hoa == XT_TSCONF);
    video_wr.palsel   = xt_wr && (hoa == XT_PALSEL);
    video_wr.hint_beg = xt_wr && (hoa == XT_HSINT);
  end

  // 128k lock mode in memconf[7:6]
  assign lock128_3 = (memconf[7:6] == 2'b11);

  always_comb
  begin
    case (memconf[7:6])
      2'b10:   lock128 = m1_lock128;   // decided by last opcode
      2'b11:   lock128 = 1'b0;
      default: lock128 = memconf[6];
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      m1_lock128 <= 1'b0;
    else if (bus.opfetch)
      m1_lock128 <= !(din[7] ^ din[6]);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rampage   <= RAMPAGE_RST;
      memconf   <= MEMCONF_RST;
      intmask   <= INTMASK_RST;
      sysconf   <= '0;   // 3.5 MHz
      cacheconf <= '0;
      fddvirt   <= '0;
    end
    else if (p7ffd_wr)
    begin
      memconf[0] <= din[4];   // rom select
      if (lock128_3)
        rampage[3] <= {2'b00, din[5], din[7:6], din[2:0]};
      else
        rampage[3] <= {3'b000, (lock128 ? 2'b00 : din[7:6]), din[2:0]};
    end
    else if (xt_wr)
    begin
      if (hoa[7:2] == XT_RAMPAGE[7:2])
        rampage[hoa[1:0]] <= din;
      if (hoa == XT_SYSCONF)
      begin
        sysconf   <= din;
        cacheconf <= {CACHECONF_W{din[2]}};   // cache follows turbo bit
      end
      if (hoa == XT_CACHECONF)
        cacheconf <= din[CACHECONF_W-1:0];
      if (hoa == XT_MEMCONF)
        memconf <= din;
      if (hoa == XT_FDDVIRT)
        fddvirt <= din;
      if (hoa == XT_INTMASK)
        intmask <= din;
    end
  end

  // 48k lock, sticks until reset
  always_ff @(posedge clk)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (p7ffd_wr && !lock128_3)
      lock48 <= din[5];
  end

  // set at reset, cleared once status has been read
  always_ff @(posedge clk)
  begin
    if (rst)
      pwr_up <= 1'b1;
    else if (hits.xt && bus.iord_s && (hoa == XT_XSTAT))
      pwr_up <= 1'b0;
  end

endmodule

`default_nettype wire

//--- fdd_ctrl.sv
// floppy control: drive select with swap, wd1793 chip select, virtual dos strobes
`timescale 1ns/100ps
`default_nettype none

module fdd_ctrl (
  input  var logic                              clk,
  input  var logic                              rst,
  input  var zports_pkg::zbus_t                 bus,
  input  var zports_pkg::port_hit_t             hits,
  input  var zports_pkg::byte_t                 fddvirt,
  input  var logic                              cfg_floppy_swap,
  output var logic                              vg_open,
  output var logic                              vg_cs_n,
  output var logic                              vdos_on,
  output var logic                              vdos_off,
  output var logic [zports_pkg::DRIVE_W-1:0]    drive_sel
);

  import zports_pkg::*;

  logic [DRIVE_W-1:0] drive_raw;
  logic               virt_vg;
  logic               any_strobe;

  // vg ports open in dos or when forced by fddvirt[7]
  assign vg_open = bus.dos || fddvirt[7];

  assign any_strobe = bus.iord_s || bus.iowr_s;

  always_ff @(posedge clk)
  begin
    if (rst)
      drive_raw <= '0;
    else if (hits.vgsys && bus.iowr_s)
      drive_raw <= bus.din[DRIVE_W-1:0];
  end

  // swap swaps A and B, C and D
  assign drive_sel = {drive_raw[1], drive_raw[0] ^ cfg_floppy_swap};

  assign virt_vg = fddvirt[drive_raw];   // raw number, before swap

  // real chip only for real drives outside virtual dos
  assign vg_cs_n = !((bus.iord || bus.iowr) && hits.vg && !bus.vdos && !virt_vg);

  assign vdos_on  = any_strobe && (hits.vg || hits.vgsys) && bus.dos &&
                    !bus.vdos && virt_vg;
  assign vdos_off = any_strobe && hits.vg && bus.vdos;

endmodule

`default_nettype wire

//--- sd_ctrl.sv
// z-controller sd card ports: chip select register and spi start
`timescale 1ns/100ps
`default_nettype none

module sd_ctrl (
  input  var logic                  clk,
  input  var logic                  rst,
  input  var zports_pkg::zbus_t     bus,
  input  var zports_pkg::port_hit_t hits,
  output var logic                  sdcs_n,
  output var logic                  sd_start,
  output var zports_pkg::byte_t     sd_datain
);

  import zports_pkg::*;

  always_ff @(posedge clk)
  begin
    if (rst)
      sdcs_n <= 1'b1;   // card deselected
    else if (hits.sdcfg && bus.iowr_s)
      sdcs_n <= bus.din[1];
  end

  // each data port access starts one spi byte
  assign sd_start = hits.sddat && (bus.iowr_s || bus.iord_s);

  // reads clock out all ones
  assign sd_datain = bus.iowr ? bus.din : byte_t'(8'hFF);

endmodule

`default_nettype wire

//--- port_rdmux.sv
// read multiplexer for the internal ports
`timescale 1ns/100ps
`default_nettype none

module port_rdmux (
  input  var zports_pkg::zbus_t                bus,
  input  var zports_pkg::port_hit_t            hits,
  input  var logic                             pwr_up,
  input  var zports_pkg::xt_pages_t            pages,
  input  var logic [zports_pkg::KEYS_W-1:0]    keys_in,
  input  var logic                             tape_read,
  input  var logic [zports_pkg::KJOY_W-1:0]    kj_in,
  input  var zports_pkg::byte_t                mus_in,
  input  var zports_pkg::byte_t                sd_dataout,
  input  var logic                             vg_intrq,
  input  var logic                             vg_drq,
  output var zports_pkg::byte_t                dout
);

  import zports_pkg::*;

  byte_t hoa;

  assign hoa = bus.addr[15:8];

  always_comb
  begin
    dout = 8'hFF;   // open bus
    if (hits.fe)
      dout = {1'b1, tape_read, 1'b0, keys_in};
    else if (hits.xt)
    begin
      if (hoa == XT_XSTAT)
        dout = {1'b0, pwr_up, 6'b000000};
      else if ((hoa == XT_RAMPAGE + 8'd2) || (hoa == XT_RAMPAGE + 8'd3))
        dout = pages[8*hoa[1:0] +: 8];
    end
    else if (hits.vgsys)
      dout = {vg_intrq, vg_drq, 6'b111111};
    else if (hits.kjoy)
      dout = {{(8-KJOY_W){1'b0}}, kj_in};
    else if (hits.kmouse)
      dout = mus_in;
    else if (hits.sdcfg)
      dout = 8'h00;   // card present, not write protected
    else if (hits.sddat)
      dout = sd_dataout;
  end

endmodule

`default_nettype wire

//--- zports_top.sv
// z80 i/o port block top that wires the decoder, register blocks and read mux together
`timescale 1ns/100ps
`default_nettype none

module zports_top (
  input  var logic                                clk,
  input  var logic                                rst,
  input  var zports_pkg::zbus_t                   bus,
  input  var logic [zports_pkg::KEYS_W-1:0]       keys_in,
  input  var logic                                tape_read,
  input  var logic [zports_pkg::KJOY_W-1:0]       kj_in,
  input  var zports_pkg::byte_t                   mus_in,
  input  var zports_pkg::byte_t                   sd_dataout,
  input  var logic                                vg_intrq,
  input  var logic                                vg_drq,
  input  var logic                                cfg_floppy_swap,
  output var zports_pkg::byte_t                   dout,
  output var logic                                porthit,
  output var logic                                external_port,
  output var logic                                dataout,
  output var zports_pkg::xt_pages_t               xt_page,
  output var zports_pkg::byte_t                   sysconf,
  output var zports_pkg::byte_t                   memconf,
  output var logic [zports_pkg::CACHECONF_W-1:0]  cacheconf,
  output var zports_pkg::byte_t                   intmask,
  output var zports_pkg::video_wr_t               video_wr,
  output var logic [zports_pkg::DRIVE_W-1:0]      drive_sel,
  output var logic                                vg_cs_n,
  output var logic                                vdos_on,
  output var logic                                vdos_off,
  output var logic                                sdcs_n,
  output var logic                                sd_start,
  output var zports_pkg::byte_t                   sd_datain
);

  import zports_pkg::*;

  port_hit_t hits;
  logic      vg_open;
  logic      pwr_up;
  byte_t     fddvirt;
  xt_pages_t pages;

  port_decode u_decode (
    .bus(bus), .vg_open(vg_open), .hits(hits),
    .sd_allow(),   // already folded into the sd hit flags
    .porthit(porthit), .external_port(external_port), .dataout(dataout)
  );

  xt_regs u_xt (
    .clk(clk), .rst(rst), .bus(bus), .hits(hits),
    .fddvirt(fddvirt), .sysconf(sysconf), .memconf(memconf), .intmask(intmask),
    .cacheconf(cacheconf), .pwr_up(pwr_up), .pages(pages), .xt_page(xt_page),
    .video_wr(video_wr)
  );

  fdd_ctrl u_fdd (
    .clk(clk), .rst(rst), .bus(bus), .hits(hits), .fddvirt(fddvirt),
    .cfg_floppy_swap(cfg_floppy_swap), .vg_open(vg_open), .vg_cs_n(vg_cs_n),
    .vdos_on(vdos_on), .vdos_off(vdos_off), .drive_sel(drive_sel)
  );

  sd_ctrl u_sd (
    .clk(clk), .rst(rst), .bus(bus), .hits(hits),
    .sdcs_n(sdcs_n), .sd_start(sd_start), .sd_datain(sd_datain)
  );

  port_rdmux u_rdmux (
    .bus(bus), .hits(hits), .pwr_up(pwr_up), .pages(pages),
    .keys_in(keys_in), .tape_read(tape_read), .kj_in(kj_in), .mus_in(mus_in),
    .sd_dataout(sd_dataout), .vg_intrq(vg_intrq), .vg_drq(vg_drq), .dout(dout)
  );

endmodule

`default_nettype wire

//--- tb_clkgen.sv
// testbench clock and reset source, reset held for a fixed number of cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
  parameter int HALF_NS    = 4,
  parameter int RST_CYCLES = 8
) (
  output var logic clk,
  output var logic rst
);

  initial
  begin
    clk = 1'b0;
    forever
      #(HALF_NS) clk = !clk;
  end

  // released just after an edge, like a synchronous reset source
  initial
  begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- zports_chk.sv
// bound checker for the sd chip select reset, vdos strobes and video write strobes
`timescale 1ns/100ps
`default_nettype none

module zports_chk (
  input var logic                  clk,
  input var logic                  rst,
  input var logic                  sdcs_n,
  input var logic                  vdos_on,
  input var logic                  vdos_off,
  input var zports_pkg::video_wr_t video_wr
);

  int fail_count = 0;   // assertion failures so far

  sdcs_after_rst: assert property (@(posedge clk) rst |=> sdcs_n)
    else
    begin
      fail_count++;
      $error("sdcs_n low in the cycle after reset");
    end

  vdos_exclusive: assert property (@(posedge clk) disable iff (rst) !(vdos_on && vdos_off))
    else
    begin
      fail_count++;
      $error("vdos_on and vdos_off high together");
    end

  // one video register per write
  video_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(video_wr))
    else
    begin
      fail_count++;
      $error("more than one video write strobe high");
    end

endmodule

bind zports_top zports_chk u_chk (
  .clk(clk), .rst(rst), .sdcs_n(sdcs_n), .vdos_on(vdos_on), .vdos_off(vdos_off),
  .video_wr(video_wr)
);

`default_nettype wire

//--- zports_tb.sv
// directed testbench for the z80 i/o port decoder and config register block
`timescale 1ns/100ps
`default_nettype none

module zports_tb;

  import zports_pkg::*;

  localparam int CLK_NS      = 8;
  localparam int TEST_CYCLES = 625;                        // bound on all tests with reset
  localparam int TIMEOUT_NS  = TEST_CYCLES * CLK_NS * 4;   // 20 us

  logic                   clk;
  logic                   rst;
  zbus_t                  bus;
  logic [KEYS_W-1:0]      keys_in;
  logic                   tape_read;
  logic [KJOY_W-1:0]      kj_in;
  byte_t                  mus_in;
  byte_t                  sd_dataout;
  logic                   vg_intrq;
  logic                   vg_drq;
  logic                   cfg_floppy_swap;
  byte_t                  dout;
  logic                   porthit;
  logic                   external_port;
  logic                   dataout;
  xt_pages_t              xt_page;
  byte_t                  sysconf;
  byte_t                  memconf;
  logic [CACHECONF_W-1:0] cacheconf;
  byte_t                  intmask;
  video_wr_t              video_wr;
  logic [DRIVE_W-1:0]     drive_sel;
  logic                   vg_cs_n;
  logic                   vdos_on;
  logic                   vdos_off;
  logic                   sdcs_n;
  logic                   sd_start;
  byte_t                  sd_datain;

  integer seed   = 8110;
  int     errors = 0;

  tb_clkgen #(.HALF_NS(CLK_NS / 2), .RST_CYCLES(8)) u_clkgen (.clk(clk), .rst(rst));

  zports_top DUT (.*);

  task automatic flag_mismatch(input string msg, input logic [31:0] got,
                               input logic [31:0] exp);
    errors++;
    $display("CHECK FAILED at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
  endtask

  // bus phase starts 1 ns after the edge, strobe covers exactly one edge
  task automatic start_access(input port_addr_t addr, input byte_t data, input logic wr);
    @(posedge clk);
    #1;
    bus.addr   = addr;
    bus.din    = data;
    bus.iowr   = wr;
    bus.iowr_s = wr;
    bus.iord   = !wr;
    bus.iord_s = !wr;
  endtask

  task automatic finish_access();
    @(posedge clk);
    #1;
    bus.iord   = 1'b0;
    bus.iowr   = 1'b0;
    bus.iord_s = 1'b0;
    bus.iowr_s = 1'b0;
  endtask

  task automatic io_write(input port_addr_t addr, input byte_t data);
    start_access(addr, data, 1'b1);
    finish_access();
  endtask

  // read one port and compare the data and the hit flags mid-cycle
  task automatic io_read(input port_addr_t addr, input byte_t exp, input logic hit,
                         input string msg);
    start_access(addr, 8'h00, 1'b0);
    @(negedge clk);
    if (dout !== exp)
      flag_mismatch(msg, dout, exp);
    if (porthit !== hit || dataout !== hit)
      flag_mismatch({msg, " hit flags"}, {porthit, dataout}, {hit, hit});
    finish_access();
  endtask

  task automatic set_mode(input logic dos, input logic vdos);
    @(posedge clk);
    #1;
    bus.dos  = dos;
    bus.vdos = vdos;
  endtask

  task automatic opcode_fetch(input byte_t op);
    @(posedge clk);
    #1;
    bus.opfetch = 1'b1;
    bus.din     = op;
    @(posedge clk);
    #1;
    bus.opfetch = 1'b0;
  endtask

  // page 3 after a 7FFD write: low 3 bits always, upper bits by lock mode
  function automatic page_t page3_rule(input logic [1:0] mode, input logic lock,
                                       input byte_t d);
    page_t p;
    p = {5'b00000, d[2:0]};
    if (mode == 2'd3)
      p[5:3] = {d[5], d[7], d[6]};
    else if (!lock)
      p[4:3] = d[7:6];
    return p;
  endfunction

  task automatic reset_values();
    io_read(16'h12AF, 8'h02, 1'b1, "ram page 2 after reset");
    io_read(16'h13AF, 8'h00, 1'b1, "ram page 3 after reset");
    if (memconf !== 8'h04)
      flag_mismatch("memconf after reset", memconf, 8'h04);
    if (intmask !== 8'h01)
      flag_mismatch("intmask after reset", intmask, 8'h01);
    if (xt_page !== 32'h0002_0500)
      flag_mismatch("ram pages after reset", xt_page, 32'h0002_0500);
    if ({sysconf, cacheconf} !== '0)
      flag_mismatch("sysconf and cacheconf after reset", {sysconf, cacheconf}, 0);
    if (sdcs_n !== 1'b1)
      flag_mismatch("sdcs_n after reset", sdcs_n, 1);
    io_read(16'h00AF, 8'h40, 1'b1, "xstat first read");
    io_read(16'h00AF, 8'h00, 1'b1, "xstat second read");
  endtask

  task automatic xt_registers();
    byte_t     data;
    xt_pages_t exp_pages;
    byte_t     vid_idx [6];
    video_wr_t vexp;
    for (int i = 0; i < 4; i++)
    begin
      data = $random(seed);
      io_write({8'h10 + i[7:0], PORT_XT}, data);
      exp_pages[8*i +: 8] = data;
    end
    if (xt_page !== exp_pages)
      flag_mismatch("xt_page after rampage writes", xt_page, exp_pages);
    io_read(16'h12AF, exp_pages[23:16], 1'b1, "ram page 2 readback");
    io_read(16'h13AF, exp_pages[31:24], 1'b1, "ram page 3 readback");
    for (int j = 0; j < 2; j++)
    begin
      data    = $random(seed);
      data[2] = j[0];
      io_write({XT_SYSCONF, PORT_XT}, data);
      if (sysconf !== data)
        flag_mismatch("sysconf", sysconf, data);
      if (cacheconf !== {CACHECONF_W{data[2]}})
        flag_mismatch("cacheconf follows sysconf bit 2", cacheconf, {4{data[2]}});
    end
    vid_idx = '{8'h00, 8'h01, 8'h0F, 8'h06, 8'h07, 8'h22};   // struct order, msb first
    for (int k = 0; k < 6; k++)
    begin
      vexp = video_wr_t'(6'b100000 >> k);
      start_access({vid_idx[k], PORT_XT}, $random(seed), 1'b1);
      @(negedge clk);
      if (video_wr !== vexp)
        flag_mismatch("video strobe in write cycle", video_wr, vexp);
      finish_access();
      @(negedge clk);
      if (video_wr !== '0)
        flag_mismatch("video strobe after write cycle", video_wr, 0);
    end
  endtask

  task automatic paging_7ffd();
    byte_t      data;
    byte_t      op;
    page_t      exp;
    logic       lock;
    logic [1:0] mode;
    for (int r = 0; r < 5; r++)   // mode 2 twice, locked then open
    begin
      mode = (r < 2) ? 2'(r) : (r < 4) ? 2'd2 : 2'd3;
      io_write({XT_MEMCONF, PORT_XT}, {mode, 6'b000100});
      lock = (mode == 2'd1);
      if (mode == 2'd2)
      begin
        op = (r == 2) ? 8'h00 : 8'h40;
        opcode_fetch(op);
        lock = !(op[7] ^ op[6]);
      end
      for (int n = 0; n < 4; n++)
      begin
        data = $random(seed);
        if (mode != 2'd3)
          data[5] = 1'b0;   // keep lock48 clear
        io_write(16'h7FFD, data);
        exp = page3_rule(mode, lock, data);
        if (xt_page[31:24] !== exp)
          flag_mismatch($sformatf("page 3 in lock mode %0d", mode), xt_page[31:24], exp);
        if (memconf[0] !== data[4])
          flag_mismatch("memconf bit 0 from 7ffd", memconf[0], data[4]);
      end
    end
    io_write(16'hFFFD, ~data);   // a15 high, not the paging port
    if (xt_page[31:24] !== exp)
      flag_mismatch("page 3 after write to fffd", xt_page[31:24], exp);
    io_write({XT_MEMCONF, PORT_XT}, 8'h04);
    data = $random(seed) | 8'h20;
    io_write(16'h7FFD, data);
    exp = page3_rule(2'd0, 1'b0, data);
    io_write(16'h7FFD, ~data);
    if (xt_page[31:24] !== exp || memconf[0] !== data[4])
      flag_mismatch("page 3 after 48k lock", xt_page[31:24], exp);
  endtask

  task automatic sd_card();
    byte_t data;
    byte_t rd;
    set_mode(1'b0, 1'b0);
    rd         = $random(seed);
    sd_dataout = rd;
    io_write({8'h00, PORT_SDCFG}, 8'h00);
    if (sdcs_n !== 1'b0)
      flag_mismatch("sdcs_n from din bit 1 clear", sdcs_n, 0);
    io_write({8'h00, PORT_SDCFG}, 8'h02);
    if (sdcs_n !== 1'b1)
      flag_mismatch("sdcs_n from din bit 1 set", sdcs_n, 1);
    data = $random(seed);
    start_access({8'h00, PORT_SDDAT}, data, 1'b1);
    @(negedge clk);
    if (sd_start !== 1'b1)
      flag_mismatch("sd_start on data write", sd_start, 1);
    if (sd_datain !== data)
      flag_mismatch("sd_datain during write", sd_datain, data);
    finish_access();
    @(negedge clk);
    if (sd_start !== 1'b0)
      flag_mismatch("sd_start after write", sd_start, 0);
    if (sd_datain !== 8'hFF)
      flag_mismatch("sd_datain when idle", sd_datain, 8'hFF);
    start_access({8'h00, PORT_SDDAT}, 8'h00, 1'b0);
    @(negedge clk);
    if (sd_start !== 1'b1)
      flag_mismatch("sd_start on data read", sd_start, 1);
    if (dout !== rd)
      flag_mismatch("sd data read", dout, rd);
    finish_access();
    io_read({8'h00, PORT_SDCFG}, 8'h00, 1'b1, "sdcfg read");
    set_mode(1'b1, 1'b0);   // plain dos hides the z-controller
    io_write({8'h00, PORT_SDCFG}, 8'h00);
    if (sdcs_n !== 1'b1)
      flag_mismatch("sdcfg write ignored in dos", sdcs_n, 1);
    set_mode(1'b1, 1'b1);
    io_write({8'h00, PORT_SDCFG}, 8'h00);
    if (sdcs_n !== 1'b0)
      flag_mismatch("sdcfg write in virtual dos", sdcs_n, 0);
    set_mode(1'b0, 1'b0);
  endtask

  task automatic floppy_control();
    byte_t      virt;
    logic [1:0] drv;
    logic       isvirt;
    virt = 8'h05;   // drives A and C virtual
    io_write({XT_FDDVIRT, PORT_XT}, virt);
    set_mode(1'b1, 1'b0);
    for (int s = 0; s < 2; s++)
    begin
      for (int d = 0; d < 4; d++)
      begin
        drv             = 2'(d);
        isvirt          = virt[d];
        cfg_floppy_swap = s[0];
        io_write({8'h00, PORT_VGSYS}, {6'b000000, drv});
        if (drive_sel !== {drv[1], drv[0] ^ s[0]})
          flag_mismatch("drive_sel", drive_sel, {drv[1], drv[0] ^ s[0]});
        start_access({8'h00, PORT_VGTRK}, 8'h00, 1'b0);
        @(negedge clk);
        if (vg_cs_n !== isvirt)
          flag_mismatch($sformatf("vg_cs_n for drive %0d", d), vg_cs_n, isvirt);
        if (vdos_on !== isvirt || vdos_off !== 1'b0)
          flag_mismatch("vdos strobes in dos", {vdos_on, vdos_off}, {isvirt, 1'b0});
        if (external_port !== 1'b1 || dataout !== 1'b0)
          flag_mismatch("vg port is external", {external_port, dataout}, 2'b10);
        finish_access();
      end
    end
    set_mode(1'b1, 1'b1);
    start_access({8'h00, PORT_VGCOM}, 8'h00, 1'b1);
    @(negedge clk);
    if ({vdos_on, vdos_off, vg_cs_n} !== 3'b011)
      flag_mismatch("vg write in virtual dos", {vdos_on, vdos_off, vg_cs_n}, 3'b011);
    finish_access();
    set_mode(1'b0, 1'b0);
    io_read({8'h00, PORT_VGTRK}, 8'hFF, 1'b0, "vg port closed outside dos");
    io_write({XT_FDDVIRT, PORT_XT}, 8'h80);   // force vg ports open, drive D real
    start_access({8'h00, PORT_VGTRK}, 8'h00, 1'b0);
    @(negedge clk);
    if (vg_cs_n !== 1'b0 || external_port !== 1'b1)
      flag_mismatch("vg port forced open", {vg_cs_n, external_port}, 2'b01);
    finish_access();
    io_write({XT_FDDVIRT, PORT_XT}, 8'h00);
  endtask

  task automatic input_ports();
    set_mode(1'b0, 1'b0);
    keys_in   = KEYS_W'($random(seed));
    tape_read = 1'($random(seed));
    kj_in     = KJOY_W'($random(seed));
    mus_in    = $random(seed);
    vg_intrq  = 1'b1;
    vg_drq    = 1'b0;
    io_read(16'h7FFE, {1'b1, tape_read, 1'b0, keys_in}, 1'b1, "port fe");
    io_read({8'h00, PORT_KJOY}, {3'b000, kj_in}, 1'b1, "kempston joystick");
    io_read({8'hFA, PORT_KMOUSE}, mus_in, 1'b1, "kempston mouse");
    io_read({8'h00, PORT_VGSYS}, 8'hFF, 1'b0, "vg system port outside dos");
    io_read(16'h0033, 8'hFF, 1'b0, "unused port");
    set_mode(1'b1, 1'b0);
    io_read({8'h00, PORT_VGSYS}, {vg_intrq, vg_drq, 6'b111111}, 1'b1, "vg system port");
    set_mode(1'b0, 1'b0);
  endtask

  initial
  begin
    bus             = '0;
    keys_in         = '0;
    tape_read       = 1'b0;
    kj_in           = '0;
    mus_in          = '0;
    sd_dataout      = '0;
    vg_intrq        = 1'b0;
    vg_drq          = 1'b0;
    cfg_floppy_swap = 1'b0;
    @(negedge rst);
    reset_values();
    xt_registers();
    paging_7ffd();
    sd_card();
    floppy_control();
    input_ports();
    $display("finished with %0d check errors and %0d assertion errors",
             errors, DUT.u_chk.fail_count);
    if (errors == 0 && DUT.u_chk.fail_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
zports_pkg.sv
port_decode.sv
xt_regs.sv
fdd_ctrl.sv
sd_ctrl.sv
port_rdmux.sv
zports_top.sv
tb_clkgen.sv
zports_chk.sv
zports_tb.sv

//--- Bender.yml
package:
  name: zports

sources:
  - zports_pkg.sv
  - port_decode.sv
  - xt_regs.sv
  - fdd_ctrl.sv
  - sd_ctrl.sv
  - port_rdmux.sv
  - zports_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - zports_chk.sv
      - zports_tb.sv
